//--- verilog/pong_defs.svh
`ifndef PONG_DEFS_SVH
`define PONG_DEFS_SVH

// Display extents for the normal and upscaled modes
`define SCREEN_W_LO 320
`define SCREEN_W_HI 640
`define SCREEN_H_LO 240
`define SCREEN_H_HI 480

// Ball geometry and start values
`define BALL_SIZE 20
`define BALL_STEP 4
`define BALL_X0   100
`define BALL_Y0   80
`define BALL_VY0  (-3)

`define PADDLE_X 8
`define PADDLE_H 48

`define SPEED_BASE_DEF 270000 // Step period in clock cycles

// Wishbone word addresses
`define REG_CTRL   3'd0
`define REG_PADDLE 3'd1
`define REG_BALL   3'd2
`define REG_STATUS 3'd3
`define REG_FRAME  3'd4

`endif

//--- verilog/pong_pkg.sv
package pong_pkg;

    typedef enum logic [1:0] {
        IDLE          = 2'd0,
        RUNNING_RIGHT = 2'd1,
        RUNNING_LEFT  = 2'd2,
        STOP          = 2'd3
    } game_state_t;

    typedef enum logic [1:0] {
        NONE  = 2'd0,
        BALL  = 2'd1,
        SCORE = 2'd2
    } frame_kind_t;

    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        logic       moving_left;
    } ball_pos_t;

    // Ball state handed over to the opposite board
    typedef struct packed {
        logic signed [7:0] vy;
        logic [1:0]        gravity_phase;
        logic [7:0]        safe_speed;
    } launch_t;

    typedef struct packed {
        frame_kind_t kind;
        launch_t     launch;
        logic [9:0]  exit_y;
        logic [1:0]  pad;
    } ball_frame_t;

    typedef struct packed {
        frame_kind_t kind;
        logic [7:0]  score;
        logic        game_over;
        logic [20:0] pad;
    } score_frame_t;

    // The kind tag sits at the top in both views
    typedef union packed {
        ball_frame_t  ball_frame;
        score_frame_t score_frame;
    } link_frame_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [2:0]  adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

//--- verilog/game_controller.sv
`timescale 1ns/1ps
`include "pong_defs.svh"

module game_controller #(
    parameter int speed_base = `SPEED_BASE_DEF
) (
    input  logic                  clk_25MHZ,
    input  logic                  reset,
    input  logic                  upscale,
    input  logic                  collision_detected,
    input  logic [7:0]            estimated_speed,
    input  logic                  game_start,
    output pong_pkg::ball_pos_t   ball,
    output logic [7:0]            score,
    output logic                  game_over,
    output pong_pkg::launch_t     launch,
    output logic                  ball_leaving,
    output logic                  score_changed,
    output pong_pkg::game_state_t state
);

    localparam logic [19:0] base_period = 20'(speed_base);

    pong_pkg::game_state_t state_next;

    logic [9:0]        x_q, x_next;
    logic [9:0]        y_q, y_next;
    logic signed [7:0] vy_q, vy_next;
    logic [1:0]        phase_q, phase_next;
    logic [19:0]       step_cnt_q, step_cnt_next;
    logic [19:0]       period_q, period_next;
    logic [7:0]        safe_q, safe_next;
    logic [7:0]        score_next;
    logic              game_over_next;
    logic              leaving_next;
    logic              score_chg_next;

    logic [9:0]        y_max;
    logic [9:0]        x_limit;
    logic              step_due;
    logic [7:0]        speed_clamped;
    logic signed [7:0] vy_grav;
    logic signed [11:0] y_sum;
    logic [9:0]        y_step;
    logic signed [7:0] vy_step;

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            state         <= pong_pkg::IDLE;
            x_q           <= 10'(`BALL_X0);
            y_q           <= 10'(`BALL_Y0);
            vy_q          <= 8'(`BALL_VY0);
            phase_q       <= 2'd0;
            step_cnt_q    <= '0;
            period_q      <= base_period;
            safe_q        <= 8'd1;
            score         <= 8'd0;
            game_over     <= 1'b0;
            ball_leaving  <= 1'b0;
            score_changed <= 1'b0;
        end else begin
            state         <= state_next;
            x_q           <= x_next;
            y_q           <= y_next;
            vy_q          <= vy_next;
            phase_q       <= phase_next;
            step_cnt_q    <= step_cnt_next;
            period_q      <= period_next;
            safe_q        <= safe_next;
            score         <= score_next;
            game_over     <= game_over_next;
            ball_leaving  <= leaving_next;
            score_changed <= score_chg_next;
        end
    end

    // One motion step, used by both directions
    always_comb begin
        y_max    = upscale ? 10'(`SCREEN_H_HI - 1) : 10'(`SCREEN_H_LO - 1);
        x_limit  = upscale ? 10'(`SCREEN_W_HI - `BALL_SIZE) : 10'(`SCREEN_W_LO - `BALL_SIZE);
        step_due = step_cnt_q >= period_q;
        speed_clamped = (estimated_speed < 8'd2) ? 8'd2 : estimated_speed;

        vy_grav = (phase_q == 2'd3) ? vy_q + 8'sd1 : vy_q; // Gravity every fourth step
        y_sum   = $signed({2'b00, y_q}) + vy_q;
        if (y_sum >= $signed({2'b00, y_max})) begin
            y_step  = y_max;
            vy_step = -vy_grav;
        end else if (y_sum <= 12'sd0) begin
            y_step  = '0;
            vy_step = -vy_grav;
        end else begin
            y_step  = y_sum[9:0];
            vy_step = vy_grav;
        end
    end

    always_comb begin
        state_next     = state;
        x_next         = x_q;
        y_next         = y_q;
        vy_next        = vy_q;
        phase_next     = phase_q;
        step_cnt_next  = step_cnt_q;
        period_next    = period_q;
        safe_next      = safe_q;
        score_next     = score;
        game_over_next = game_over;
        leaving_next   = 1'b0;
        score_chg_next = 1'b0;

        case (state)
            pong_pkg::IDLE, pong_pkg::STOP: begin
                if (game_start) begin
                    state_next     = pong_pkg::RUNNING_LEFT;
                    x_next         = 10'(`BALL_X0);
                    y_next         = 10'(`BALL_Y0);
                    vy_next        = 8'(`BALL_VY0);
                    phase_next     = 2'd0;
                    step_cnt_next  = '0;
                    period_next    = base_period;
                    safe_next      = 8'd1;
                    score_next     = 8'd0;
                    game_over_next = 1'b0;
                end
            end

            pong_pkg::RUNNING_LEFT: begin
                if (collision_detected) begin
                    // Returned by the paddle, so the ball speeds up with the swing
                    state_next    = pong_pkg::RUNNING_RIGHT;
                    step_cnt_next = '0;
                    phase_next    = 2'd0;
                    safe_next     = speed_clamped;
                    period_next   = base_period / {12'd0, speed_clamped};
                end else if (x_q == 10'd0) begin
                    state_next     = pong_pkg::RUNNING_RIGHT;
                    score_next     = score + 8'd1;
                    score_chg_next = 1'b1;
                    step_cnt_next  = '0;
                    phase_next     = 2'd0;
                    period_next    = base_period;
                    safe_next      = 8'd1;
                end else if (step_due) begin
                    x_next        = x_q - 10'(`BALL_STEP);
                    y_next        = y_step;
                    vy_next       = vy_step;
                    phase_next    = phase_q + 2'd1;
                    step_cnt_next = '0;
                end else begin
                    step_cnt_next = step_cnt_q + 20'd1;
                end
            end

            pong_pkg::RUNNING_RIGHT: begin
                if (x_q >= x_limit) begin
                    state_next     = pong_pkg::STOP;
                    game_over_next = 1'b1;
                    leaving_next   = 1'b1; // Ball crosses to the other board
                end else if (step_due) begin
                    x_next        = x_q + 10'(`BALL_STEP);
                    y_next        = y_step;
                    vy_next       = vy_step;
                    phase_next    = phase_q + 2'd1;
                    step_cnt_next = '0;
                end else begin
                    step_cnt_next = step_cnt_q + 20'd1;
                end
            end

            default: state_next = pong_pkg::IDLE;
        endcase
    end

    assign ball   = '{x: x_q, y: y_q, moving_left: state == pong_pkg::RUNNING_LEFT};
    assign launch = '{vy: vy_q, gravity_phase: phase_q, safe_speed: safe_q};

endmodule

//--- verilog/paddle_tracker.sv
`timescale 1ns/1ps
`include "pong_defs.svh"

module paddle_tracker (
    input  logic                clk_25MHZ,
    input  logic                reset,
    input  logic [9:0]          paddle_y,
    input  logic                paddle_update,
    input  pong_pkg::ball_pos_t ball,
    output logic [7:0]          estimated_speed,
    output logic                collision_detected
);

    logic [9:0]  prev_y;
    logic [9:0]  delta;
    logic [10:0] ball_bottom;
    logic [10:0] paddle_bottom;
    logic        near_paddle;
    logic        rows_overlap;

    always_comb begin
        delta = (paddle_y >= prev_y) ? paddle_y - prev_y : prev_y - paddle_y;

        // Spans are half open so touching edges do not count
        ball_bottom   = {1'b0, ball.y} + 11'(`BALL_SIZE);
        paddle_bottom = {1'b0, paddle_y} + 11'(`PADDLE_H);
        rows_overlap  = ({1'b0, paddle_y} < ball_bottom) && ({1'b0, ball.y} < paddle_bottom);
        near_paddle   = ball.moving_left && (ball.x <= 10'(`PADDLE_X + `BALL_SIZE));
    end

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            prev_y             <= '0;
            estimated_speed    <= 8'd0;
            collision_detected <= 1'b0;
        end else begin
            collision_detected <= near_paddle && rows_overlap;
            if (paddle_update) begin
                prev_y          <= paddle_y;
                estimated_speed <= (delta > 10'd255) ? 8'd255 : delta[7:0]; // Saturate
            end
        end
    end

endmodule

//--- verilog/link_mailbox.sv
`timescale 1ns/1ps

module link_mailbox (
    input  logic                  clk_25MHZ,
    input  logic                  reset,
    input  pong_pkg::ball_pos_t   ball,
    input  logic [7:0]            score,
    input  logic                  game_over,
    input  pong_pkg::launch_t     launch,
    input  logic                  ball_leaving,
    input  logic                  score_changed,
    input  logic                  frame_read,
    output pong_pkg::link_frame_t frame,
    output logic                  frame_valid
);

    pong_pkg::link_frame_t frame_next;
    logic                  post;

    assign post = ball_leaving || score_changed;

    // A leaving ball wins over a score change in the same cycle
    always_comb begin
        frame_next = '0;
        if (ball_leaving) begin
            frame_next.ball_frame.kind   = pong_pkg::BALL;
            frame_next.ball_frame.launch = launch;
            frame_next.ball_frame.exit_y = ball.y;
        end else begin
            frame_next.score_frame.kind      = pong_pkg::SCORE;
            frame_next.score_frame.score     = score;
            frame_next.score_frame.game_over = game_over;
        end
    end

    always_ff @(posedge clk_25MHZ) begin
        if (post) begin
            frame <= frame_next; // Newest frame replaces an unread one
        end
    end

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            frame_valid <= 1'b0;
        end else if (post) begin
            frame_valid <= 1'b1;
        end else if (frame_read) begin
            frame_valid <= 1'b0;
        end
    end

endmodule

//--- verilog/wb_game_regs.sv
`timescale 1ns/1ps
`include "pong_defs.svh"

module wb_game_regs (
    input  logic                  clk_25MHZ,
    input  logic                  reset,
    input  pong_pkg::wb_req_t     wb_req,
    output pong_pkg::wb_rsp_t     wb_rsp,
    output logic                  game_start,
    output logic                  upscale,
    output logic [9:0]            paddle_y,
    output logic                  paddle_update,
    output logic                  frame_read,
    input  pong_pkg::ball_pos_t   ball,
    input  logic [7:0]            score,
    input  logic                  game_over,
    input  pong_pkg::game_state_t state,
    input  pong_pkg::link_frame_t frame,
    input  logic                  frame_valid
);

    logic        ack_q;
    logic        served_q; // Strobe already answered and still held
    logic        access;
    logic        wr_en;
    logic [31:0] rd_data;

    assign access = wb_req.cyc && wb_req.stb && !ack_q && !served_q;
    assign wr_en  = access && wb_req.we;

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            ack_q         <= 1'b0;
            served_q      <= 1'b0;
            game_start    <= 1'b0;
            upscale       <= 1'b0;
            paddle_y      <= '0;
            paddle_update <= 1'b0;
        end else begin
            ack_q         <= access;
            served_q      <= wb_req.cyc && wb_req.stb && (ack_q || served_q);
            game_start    <= wr_en && (wb_req.adr == `REG_CTRL) && wb_req.sel[0] && wb_req.dat[0];
            paddle_update <= wr_en && (wb_req.adr == `REG_PADDLE);
            if (wr_en && (wb_req.adr == `REG_CTRL) && wb_req.sel[0]) begin
                upscale <= wb_req.dat[1];
            end
            if (wr_en && (wb_req.adr == `REG_PADDLE)) begin
                if (wb_req.sel[0]) paddle_y[7:0] <= wb_req.dat[7:0];
                if (wb_req.sel[1]) paddle_y[9:8] <= wb_req.dat[9:8];
            end
        end
    end

    always_comb begin
        case (wb_req.adr)
            `REG_CTRL:   rd_data = {30'd0, upscale, 1'b0};
            `REG_PADDLE: rd_data = {22'd0, paddle_y};
            `REG_BALL:   rd_data = {ball.moving_left, 5'd0, ball.y, 6'd0, ball.x};
            `REG_STATUS: rd_data = {20'd0, state, frame_valid, game_over, score};
            `REG_FRAME:  rd_data = frame_valid ? frame : 32'd0; // Kind NONE when empty
            default:     rd_data = 32'd0;
        endcase
    end

    // Reading the frame empties the mailbox at the end of the ack cycle
    assign frame_read = ack_q && !wb_req.we && (wb_req.adr == `REG_FRAME);

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = ack_q ? rd_data : 32'd0;

endmodule

//--- verilog/pong_core.sv
`timescale 1ns/1ps
`include "pong_defs.svh"

module pong_core #(
    parameter int speed_base = `SPEED_BASE_DEF
) (
    input  logic              clk_25MHZ,
    input  logic              reset,
    input  pong_pkg::wb_req_t wb_req,
    output pong_pkg::wb_rsp_t wb_rsp
);

    pong_pkg::ball_pos_t   ball;
    pong_pkg::launch_t     launch;
    pong_pkg::game_state_t state;
    pong_pkg::link_frame_t frame;

    logic [7:0] score;
    logic       game_over;
    logic       ball_leaving;
    logic       score_changed;
    logic       frame_valid;
    logic       frame_read;
    logic       game_start;
    logic       upscale;
    logic [9:0] paddle_y;
    logic       paddle_update;
    logic [7:0] estimated_speed;
    logic       collision_detected;

    wb_game_regs u_regs (
        .clk_25MHZ, .reset, .wb_req, .wb_rsp,
        .game_start, .upscale, .paddle_y, .paddle_update, .frame_read,
        .ball, .score, .game_over, .state, .frame, .frame_valid
    );

    paddle_tracker u_tracker (
        .clk_25MHZ, .reset, .paddle_y, .paddle_update, .ball,
        .estimated_speed, .collision_detected
    );

    game_controller #(.speed_base(speed_base)) u_ctrl (
        .clk_25MHZ, .reset, .upscale, .collision_detected, .estimated_speed, .game_start,
        .ball, .score, .game_over, .launch, .ball_leaving, .score_changed, .state
    );

    link_mailbox u_mailbox (
        .clk_25MHZ, .reset, .ball, .score, .game_over, .launch,
        .ball_leaving, .score_changed, .frame_read, .frame, .frame_valid
    );

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int period_ns = 40
) (
    output logic clk_25MHZ
);

    initial clk_25MHZ = 1'b0;

    always #(period_ns / 2) clk_25MHZ = ~clk_25MHZ; // 25 MHz

endmodule

//--- sim/pong_assertions.sv
`timescale 1ns/1ps
`include "pong_defs.svh"

module pong_assertions (
    input logic                clk_25MHZ,
    input logic                reset,
    input pong_pkg::wb_req_t   wb_req,
    input pong_pkg::wb_rsp_t   wb_rsp,
    input pong_pkg::ball_pos_t ball,
    input logic                upscale
);

    // Each strobe gets exactly one ack cycle
    ack_single: assert property (@(posedge clk_25MHZ) disable iff (reset)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("Wishbone ack lasted two cycles");

    ball_row_limit: assert property (@(posedge clk_25MHZ) disable iff (reset)
        ball.y <= (upscale ? 10'(`SCREEN_H_HI - 1) : 10'(`SCREEN_H_LO - 1)))
        else $error("Ball row %0d beyond the screen height", ball.y);

    ball_col_limit: assert property (@(posedge clk_25MHZ) disable iff (reset)
        ball.x <= (upscale ? 10'(`SCREEN_W_HI - `BALL_SIZE) : 10'(`SCREEN_W_LO - `BALL_SIZE)))
        else $error("Ball column %0d beyond the exit column", ball.x);

endmodule

//--- sim/tb_pong.sv
`timescale 1ns/1ps
`include "pong_defs.svh"

module tb_pong;

    localparam int speed_base  = 16;
    localparam int step_cycles = speed_base + 1;
    // Eight full-width crossings at base speed cover all five tests with margin
    localparam int watchdog_cycles = 8 * (`SCREEN_W_HI / `BALL_STEP) * step_cycles;

    logic              clk_25MHZ;
    logic              reset;
    pong_pkg::wb_req_t wb_req;
    pong_pkg::wb_rsp_t wb_rsp;

    int errors = 0;
    int checks = 0;

    tb_clock u_clock (.clk_25MHZ);

    pong_core #(.speed_base(speed_base)) dut (.clk_25MHZ, .reset, .wb_req, .wb_rsp);

    bind wb_game_regs pong_assertions u_assertions (
        .clk_25MHZ, .reset, .wb_req, .wb_rsp, .ball, .upscale
    );

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic report(input string what);
        errors++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    // Holds the request through the ack cycle, then leaves the strobe low for one cycle
    task automatic bus_cycle(input logic write, input logic [2:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: write, adr: addr, dat: wdata, sel: 4'hf};
        @(negedge clk_25MHZ);
        while (!wb_rsp.ack && waited < 4) begin
            waited++;
            @(negedge clk_25MHZ);
        end
        if (!wb_rsp.ack) begin
            report($sformatf("no ack within 4 cycles at address %0d", addr));
        end
        rdata  = wb_rsp.dat;
        @(negedge clk_25MHZ);
        wb_req = '0;
        @(negedge clk_25MHZ);
    endtask

    task automatic wb_write(input logic [2:0] addr, input logic [31:0] wdata);
        logic [31:0] unused;
        bus_cycle(1'b1, addr, wdata, unused);
    endtask

    task automatic wb_read(input logic [2:0] addr, output logic [31:0] rdata);
        bus_cycle(1'b0, addr, 32'd0, rdata);
    endtask

    // Status word: state [11:10], frame_valid [9], game_over [8], score [7:0]
    task automatic wait_for_state(input pong_pkg::game_state_t st, input int max_reads,
                                  output logic [31:0] status);
        int n;
        n = 0;
        do begin
            wb_read(`REG_STATUS, status);
            n++;
        end while (status[11:10] != st && n < max_reads);
        if (status[11:10] != st) begin
            report($sformatf("game never reached state %s", st.name()));
        end
    endtask

    task automatic reset_values();
        logic [31:0] rd;
        int acks;
        wb_read(`REG_BALL, rd);
        check("ball.x", rd[9:0], `BALL_X0);
        check("ball.y", rd[25:16], `BALL_Y0);
        check("ball.moving_left", rd[31], 0);
        wb_read(`REG_STATUS, rd);
        check("score", rd[7:0], 0);
        check("game_over", rd[8], 0);
        check("frame_valid", rd[9], 0);
        check("state", rd[11:10], pong_pkg::IDLE);
        for (int a = 5; a < 8; a++) begin
            wb_read(3'(a), rd);
            check($sformatf("read data at address %0d", a), rd, 0);
        end
        // A strobe held for four cycles still gets a single ack
        acks = 0;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: `REG_BALL, dat: 32'd0, sel: 4'hf};
        repeat (4) begin
            @(negedge clk_25MHZ);
            if (wb_rsp.ack) acks++;
        end
        wb_req = '0;
        @(negedge clk_25MHZ);
        check("ack cycles per strobe", acks, 1);
    endtask

    task automatic miss_at_left_wall();
        logic [31:0]           rd;
        logic [9:0]            prev_x;
        int                    n;
        pong_pkg::link_frame_t f;
        wb_write(`REG_PADDLE, 400); // Below the low resolution screen
        wb_write(`REG_CTRL, 32'h1);
        prev_x = `BALL_X0;
        n = 0;
        do begin
            wb_read(`REG_BALL, rd);
            if (rd[31]) begin
                check("ball.x moving left", rd[9:0] <= prev_x, 1);
                check("ball.x step remainder", (prev_x - rd[9:0]) % `BALL_STEP, 0);
                prev_x = rd[9:0];
            end
            n++;
        end while (rd[31] && n < 1000);
        if (rd[31]) report("ball never turned at the left wall");
        wb_read(`REG_STATUS, rd);
        check("score", rd[7:0], 1);
        check("game_over", rd[8], 0);
        check("frame_valid", rd[9], 1);
        wb_read(`REG_FRAME, rd);
        f = rd;
        check("frame kind", f.score_frame.kind, pong_pkg::SCORE);
        check("frame score", f.score_frame.score, 1);
        check("frame game_over", f.score_frame.game_over, 0);
        wb_read(`REG_STATUS, rd);
        check("frame_valid after read", rd[9], 0);
        wb_read(`REG_FRAME, rd);
        f = rd;
        check("frame kind when empty", f.score_frame.kind, pong_pkg::NONE);
    endtask

    task automatic exit_to_right();
        logic [31:0]           rd;
        logic [9:0]            exit_y;
        pong_pkg::link_frame_t f;
        wait_for_state(pong_pkg::STOP, 2000, rd);
        check("game_over", rd[8], 1);
        check("score", rd[7:0], 1);
        check("frame_valid", rd[9], 1);
        wb_read(`REG_BALL, rd);
        exit_y = rd[25:16];
        check("ball.x at exit", rd[9:0], `SCREEN_W_LO - `BALL_SIZE);
        wb_read(`REG_FRAME, rd);
        f = rd;
        check("frame kind", f.ball_frame.kind, pong_pkg::BALL);
        // The phase restarts at the wall and counts the rightward steps modulo four
        check("gravity phase", f.ball_frame.launch.gravity_phase,
              ((`SCREEN_W_LO - `BALL_SIZE) / `BALL_STEP) % 4);
        check("gravity phase nonzero", f.ball_frame.launch.gravity_phase != 0, 1);
        check("safe_speed", f.ball_frame.launch.safe_speed, 1);
        check("exit_y", f.ball_frame.exit_y, exit_y);
    endtask

    task automatic paddle_return();
        logic [31:0]           rd;
        logic [9:0]            paddle_top;
        logic [9:0]            last_left_x;
        int                    diff;
        int                    n;
        pong_pkg::link_frame_t f;
        wb_write(`REG_CTRL, 32'h1);
        n = 0;
        do begin
            wb_read(`REG_BALL, rd);
            n++;
        end while (!(rd[31] && rd[9:0] <= `PADDLE_X + `BALL_SIZE + `BALL_STEP) && n < 1000);
        if (!rd[31]) report("ball never came near the paddle");
        diff = $urandom % 41;
        // 14 rows above the ball keeps the next ball row inside the paddle
        paddle_top = (rd[25:16] >= 10'd14) ? rd[25:16] - 10'd14 : 10'd0;
        wb_write(`REG_PADDLE, paddle_top + diff);
        wb_write(`REG_PADDLE, paddle_top);
        last_left_x = rd[9:0];
        n = 0;
        do begin
            wb_read(`REG_BALL, rd);
            if (rd[31]) last_left_x = rd[9:0];
            n++;
        end while (rd[31] && n < 1000);
        // The ball turns on the first step that reaches the paddle column
        check("ball turned at the paddle", last_left_x >= `PADDLE_X + `BALL_SIZE, 1);
        wb_read(`REG_STATUS, rd);
        check("score after paddle return", rd[7:0], 0);
        wait_for_state(pong_pkg::STOP, 2000, rd);
        wb_read(`REG_FRAME, rd);
        f = rd;
        check("frame kind", f.ball_frame.kind, pong_pkg::BALL);
        check("safe_speed", f.ball_frame.launch.safe_speed, (diff < 2) ? 2 : diff);
    endtask

    task automatic upscale_round();
        logic [31:0] rd;
        logic [31:0] status;
        int          n;
        wb_write(`REG_PADDLE, 900); // Below the upscaled screen
        wb_write(`REG_CTRL, 32'h3);
        wb_read(`REG_CTRL, rd);
        check("upscale", rd[1], 1);
        n = 0;
        do begin
            wb_read(`REG_BALL, rd);
            check("ball.y within the upscaled screen", rd[25:16] <= `SCREEN_H_HI - 1, 1);
            wb_read(`REG_STATUS, status);
            n++;
        end while (status[11:10] != pong_pkg::STOP && n < 2000);
        if (status[11:10] != pong_pkg::STOP) report("upscaled game never stopped");
        wb_read(`REG_BALL, rd);
        check("ball.x at exit", rd[9:0], `SCREEN_W_HI - `BALL_SIZE);
        check("game_over", status[8], 1);
        check("score", status[7:0], 1);
    endtask

    initial begin
        wb_req = '0;
        reset  = 1'b1;
        void'($urandom(32'hd506d476));
        repeat (10) @(posedge clk_25MHZ);
        @(negedge clk_25MHZ);
        reset = 1'b0;
        @(negedge clk_25MHZ);
        reset_values();
        miss_at_left_wall();
        exit_to_right();
        paddle_return();
        upscale_round();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk_25MHZ);
        $display("Watchdog expired after %0d cycles, checks run: %0d, errors: %0d",
                 watchdog_cycles, checks, errors);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- sim.f
+incdir+verilog
verilog/pong_pkg.sv
verilog/game_controller.sv
verilog/paddle_tracker.sv
verilog/link_mailbox.sv
verilog/wb_game_regs.sv
verilog/pong_core.sv
sim/tb_clock.sv
sim/pong_assertions.sv
sim/tb_pong.sv
